// File: design/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

//////////////////////////////////////////////////
// register file sizes
//////////////////////////////////////////////////

// architectural registers, alpha has 32
`define NUM_ARCH_REG     32
// r31 reads as zero, never renamed
`define ZERO_REG         31
`define NUM_PHYS_REG     40
`define PHYS_TAG_W       6

//////////////////////////////////////////////////
// queue depths
//////////////////////////////////////////////////

// spare physical tags beyond the arch set
`define FREE_LIST_DEPTH  (`NUM_PHYS_REG - `NUM_ARCH_REG)
`define ROB_DEPTH        16

//////////////////////////////////////////////////
// opcodes
//////////////////////////////////////////////////

// operate group
`define OPC_INTA         6'h10
`define OPC_INTL         6'h11
`define OPC_INTS         6'h12
`define OPC_INTM         6'h13
// loads
`define OPC_LDL          6'h28
`define OPC_LDQ          6'h29
// stores
`define OPC_STL          6'h2c
`define OPC_STQ          6'h2d

`endif

// File: design/rename_pkg.sv
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

  //////////////////////////////////////////////////
  // register ids
  //////////////////////////////////////////////////

  // architectural register index
  typedef logic [4:0] arch_reg_t;

  // physical tag
  typedef logic [`PHYS_TAG_W-1:0] phys_tag_t;

  //////////////////////////////////////////////////
  // instruction word
  //////////////////////////////////////////////////

  // operate format, rc is the destination
  typedef struct packed {
    logic [5:0]  opcode;
    arch_reg_t   ra;
    arch_reg_t   rb;
    // sbz or literal, literal flag, function code
    logic [10:0] lit_func;
    arch_reg_t   rc;
  } op_fmt_t;

  // memory format, ra is data reg and rb the base
  typedef struct packed {
    logic [5:0]  opcode;
    arch_reg_t   ra;
    arch_reg_t   rb;
    logic [15:0] disp;
  } mem_fmt_t;

  // same 32 bits, decoded by opcode group
  typedef union packed {
    op_fmt_t  op;
    mem_fmt_t mem;
  } inst_word_t;

  //////////////////////////////////////////////////
  // reorder buffer entry
  //////////////////////////////////////////////////

  typedef struct packed {
    arch_reg_t arch_dest;
    phys_tag_t new_tag;
    // previous mapping, freed at retire
    phys_tag_t old_tag;
    logic      has_dest;
    logic      done;
  } rob_entry_t;

endpackage

`default_nettype wire

// File: design/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module map_table
  import rename_pkg::*;
(
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      rename_en,
  input  wire arch_reg_t rename_reg,
  input  wire phys_tag_t rename_tag,
  input  wire arch_reg_t src_a_reg,
  input  wire arch_reg_t src_b_reg,
  input  wire logic      complete_valid,
  input  wire phys_tag_t complete_tag,
  output phys_tag_t      src_a_tag,
  output logic           src_a_ready,
  output phys_tag_t      src_b_tag,
  output logic           src_b_ready,
  output phys_tag_t      old_tag
);

  // current mapping per arch reg
  phys_tag_t                  map_tag   [`NUM_ARCH_REG];
  logic [`NUM_ARCH_REG-1:0]   map_ready;

  //////////////////////////////////////////////////
  // lookups
  //////////////////////////////////////////////////

  // state before the edge, no completion bypass
  assign src_a_tag   = map_tag[src_a_reg];
  assign src_a_ready = map_ready[src_a_reg];
  assign src_b_tag   = map_tag[src_b_reg];
  assign src_b_ready = map_ready[src_b_reg];

  // mapping being replaced, travels to the rob
  assign old_tag = map_tag[rename_reg];

  //////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, all values present
      for (int i = 0; i < `NUM_ARCH_REG; i++) begin
        map_tag[i]   <= phys_tag_t'(i);
        map_ready[i] <= 1'b1;
      end
    end else begin
      // cam match against the completing tag
      for (int i = 0; i < `NUM_ARCH_REG; i++) begin
        if (complete_valid && (map_tag[i] == complete_tag)) begin
          map_ready[i] <= 1'b1;
        end
      end
      // rename wins over completion on the same entry
      if (rename_en) begin
        map_tag[rename_reg]   <= rename_tag;
        map_ready[rename_reg] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list
  import rename_pkg::*;
(
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      pop,
  input  wire logic      push,
  input  wire phys_tag_t push_tag,
  output phys_tag_t      head_tag,
  output logic           empty
);

  localparam int PTR_W = $clog2(`FREE_LIST_DEPTH);
  localparam int CNT_W = $clog2(`FREE_LIST_DEPTH + 1);

  phys_tag_t            fl_mem [`FREE_LIST_DEPTH];
  logic [PTR_W-1:0]     head;
  logic [PTR_W-1:0]     tail;
  logic [CNT_W-1:0]     count;

  // wrap at depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`FREE_LIST_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // oldest free tag goes out first
  assign head_tag = fl_mem[head];
  assign empty    = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // spare tags 32 and up, queue full
      for (int i = 0; i < `FREE_LIST_DEPTH; i++) begin
        fl_mem[i] <= phys_tag_t'(`NUM_ARCH_REG + i);
      end
      head  <= '0;
      tail  <= '0;
      count <= CNT_W'(`FREE_LIST_DEPTH);
    end else begin
      if (pop) begin
        head <= ptr_inc(head);
      end
      // freed tag appended at the back
      if (push) begin
        fl_mem[tail] <= push_tag;
        tail         <= ptr_inc(tail);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module dispatch_stage
  import rename_pkg::*;
(
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       dispatch_valid,
  input  wire inst_word_t dispatch_inst,
  input  wire logic       rob_full,
  input  wire logic       complete_valid,
  input  wire phys_tag_t  complete_tag,
  input  wire logic       recycle_valid,
  input  wire phys_tag_t  recycle_tag,
  output logic            dispatch_ready,
  output logic            dispatch_fire,
  output logic            dispatch_has_dest,
  output arch_reg_t       dispatch_arch_dest,
  output phys_tag_t       dispatch_dest_tag,
  output phys_tag_t       dispatch_old_tag,
  output phys_tag_t       src_a_tag,
  output phys_tag_t       src_b_tag,
  output logic            src_a_ready,
  output logic            src_b_ready
);

  logic [5:0] opcode;
  arch_reg_t  dest_reg;
  arch_reg_t  src_a_reg;
  arch_reg_t  src_b_reg;
  logic       rename_en;
  logic       fl_empty;
  phys_tag_t  fl_head_tag;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  // opcode sits in the same bits for both views
  assign opcode = dispatch_inst.op.opcode;

  always_comb begin
    // unknown opcodes touch only r31
    dest_reg  = arch_reg_t'(`ZERO_REG);
    src_a_reg = arch_reg_t'(`ZERO_REG);
    src_b_reg = arch_reg_t'(`ZERO_REG);
    case (opcode)
      `OPC_INTA, `OPC_INTL, `OPC_INTS, `OPC_INTM: begin
        dest_reg  = dispatch_inst.op.rc;
        src_a_reg = dispatch_inst.op.ra;
        src_b_reg = dispatch_inst.op.rb;
      end
      `OPC_LDL, `OPC_LDQ: begin
        // load writes ra, only base is read
        dest_reg  = dispatch_inst.mem.ra;
        src_b_reg = dispatch_inst.mem.rb;
      end
      `OPC_STL, `OPC_STQ: begin
        // store reads data and base
        src_a_reg = dispatch_inst.mem.ra;
        src_b_reg = dispatch_inst.mem.rb;
      end
      default: begin
      end
    endcase
  end

  // a write to r31 is discarded
  assign dispatch_has_dest  = (dest_reg != arch_reg_t'(`ZERO_REG));
  assign dispatch_arch_dest = dest_reg;

  //////////////////////////////////////////////////
  // stall and acceptance
  //////////////////////////////////////////////////

  // structural hazards only, independent of the word
  assign dispatch_ready = !rob_full && !fl_empty;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;
  assign rename_en      = dispatch_fire && dispatch_has_dest;

  // no destination shows r31 and takes no tag
  assign dispatch_dest_tag = dispatch_has_dest ? fl_head_tag : phys_tag_t'(`ZERO_REG);

  map_table u_map (
    .clock          (clock),
    .reset          (reset),
    .rename_en      (rename_en),
    .rename_reg     (dest_reg),
    .rename_tag     (fl_head_tag),
    .src_a_reg      (src_a_reg),
    .src_b_reg      (src_b_reg),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .src_a_tag      (src_a_tag),
    .src_a_ready    (src_a_ready),
    .src_b_tag      (src_b_tag),
    .src_b_ready    (src_b_ready),
    .old_tag        (dispatch_old_tag)
  );

  // popped on rename, refilled by retire
  free_list u_free_list (
    .clock    (clock),
    .reset    (reset),
    .pop      (rename_en),
    .push     (recycle_valid),
    .push_tag (recycle_tag),
    .head_tag (fl_head_tag),
    .empty    (fl_empty)
  );

endmodule

`default_nettype wire

// File: design/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module reorder_buffer
  import rename_pkg::*;
(
  input  wire logic      clock,
  input  wire logic      reset,
  // allocation from dispatch
  input  wire logic      dispatch_fire,
  input  wire logic      dispatch_has_dest,
  input  wire arch_reg_t dispatch_arch_dest,
  input  wire phys_tag_t dispatch_dest_tag,
  input  wire phys_tag_t dispatch_old_tag,
  // completion broadcast
  input  wire logic      complete_valid,
  input  wire phys_tag_t complete_tag,
  output logic           full,
  // retire port
  output logic           retire_valid,
  output arch_reg_t      retire_arch_reg,
  output phys_tag_t      retire_new_tag,
  output phys_tag_t      retire_old_tag,
  output logic           retire_has_dest,
  // old tag back to the free list
  output logic           recycle_valid,
  output phys_tag_t      recycle_tag
);

  localparam int PTR_W = $clog2(`ROB_DEPTH);
  localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

  rob_entry_t            rob_mem [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] rob_valid;
  logic [PTR_W-1:0]      head;
  logic [PTR_W-1:0]      tail;
  logic [CNT_W-1:0]      count;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`ROB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // head and retire
  //////////////////////////////////////////////////

  assign full = (count == CNT_W'(`ROB_DEPTH));

  // no back-pressure, a done head always leaves
  assign retire_valid    = rob_valid[head] && rob_mem[head].done;
  assign retire_arch_reg = rob_mem[head].arch_dest;
  assign retire_new_tag  = rob_mem[head].new_tag;
  assign retire_old_tag  = rob_mem[head].old_tag;
  assign retire_has_dest = rob_mem[head].has_dest;

  assign recycle_valid = retire_valid && retire_has_dest;
  assign recycle_tag   = rob_mem[head].old_tag;

  //////////////////////////////////////////////////
  // entry payload
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    // tag match over live entries with a destination
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      if (complete_valid && rob_valid[i] && rob_mem[i].has_dest &&
          (rob_mem[i].new_tag == complete_tag)) begin
        rob_mem[i].done <= 1'b1;
      end
    end
    if (dispatch_fire) begin
      rob_mem[tail].arch_dest <= dispatch_arch_dest;
      rob_mem[tail].new_tag   <= dispatch_dest_tag;
      rob_mem[tail].old_tag   <= dispatch_old_tag;
      rob_mem[tail].has_dest  <= dispatch_has_dest;
      // nothing to wait for without a destination
      rob_mem[tail].done      <= !dispatch_has_dest;
    end
  end

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      rob_valid <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (dispatch_fire) begin
        rob_valid[tail] <= 1'b1;
        tail            <= ptr_inc(tail);
      end
      if (retire_valid) begin
        rob_valid[head] <= 1'b0;
        head            <= ptr_inc(head);
      end
      case ({dispatch_fire, retire_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core
  import rename_pkg::*;
(
  input  wire logic       clock,
  input  wire logic       reset,
  // dispatch side
  input  wire logic       dispatch_valid,
  input  wire inst_word_t dispatch_inst,
  output logic            dispatch_ready,
  output logic            dispatch_has_dest,
  output phys_tag_t       dispatch_dest_tag,
  output phys_tag_t       src_a_tag,
  output phys_tag_t       src_b_tag,
  output logic            src_a_ready,
  output logic            src_b_ready,
  // completion broadcast
  input  wire logic       complete_valid,
  input  wire phys_tag_t  complete_tag,
  // retire port
  output logic            retire_valid,
  output logic            retire_has_dest,
  output arch_reg_t       retire_arch_reg,
  output phys_tag_t       retire_new_tag,
  output phys_tag_t       retire_old_tag
);

  // dispatch to rob
  logic      rob_full;
  logic      dispatch_fire;
  arch_reg_t dispatch_arch_dest;
  phys_tag_t dispatch_old_tag;
  // rob back to free list
  logic      recycle_valid;
  phys_tag_t recycle_tag;

  // decode, rename and stall
  dispatch_stage u_dispatch (
    .clock              (clock),
    .reset              (reset),
    .dispatch_valid     (dispatch_valid),
    .dispatch_inst      (dispatch_inst),
    .rob_full           (rob_full),
    .complete_valid     (complete_valid),
    .complete_tag       (complete_tag),
    .recycle_valid      (recycle_valid),
    .recycle_tag        (recycle_tag),
    .dispatch_ready     (dispatch_ready),
    .dispatch_fire      (dispatch_fire),
    .dispatch_has_dest  (dispatch_has_dest),
    .dispatch_arch_dest (dispatch_arch_dest),
    .dispatch_dest_tag  (dispatch_dest_tag),
    .dispatch_old_tag   (dispatch_old_tag),
    .src_a_tag          (src_a_tag),
    .src_b_tag          (src_b_tag),
    .src_a_ready        (src_a_ready),
    .src_b_ready        (src_b_ready)
  );

  // in-order tracking and retire
  reorder_buffer u_rob (
    .clock              (clock),
    .reset              (reset),
    .dispatch_fire      (dispatch_fire),
    .dispatch_has_dest  (dispatch_has_dest),
    .dispatch_arch_dest (dispatch_arch_dest),
    .dispatch_dest_tag  (dispatch_dest_tag),
    .dispatch_old_tag   (dispatch_old_tag),
    .complete_valid     (complete_valid),
    .complete_tag       (complete_tag),
    .full               (rob_full),
    .retire_valid       (retire_valid),
    .retire_arch_reg    (retire_arch_reg),
    .retire_new_tag     (retire_new_tag),
    .retire_old_tag     (retire_old_tag),
    .retire_has_dest    (retire_has_dest),
    .recycle_valid      (recycle_valid),
    .recycle_tag        (recycle_tag)
  );

endmodule

`default_nettype wire

// File: dv/rename_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_core_assertions
  import rename_pkg::*;
(
  input wire logic      clock,
  input wire logic      reset,
  input wire logic      dispatch_valid,
  input wire logic      dispatch_ready,
  input wire logic      dispatch_has_dest,
  input wire logic      retire_valid,
  input wire logic      retire_has_dest,
  input wire phys_tag_t retire_new_tag
);

  // read by the testbench at the end of the run
  int unsigned fail_count = 0;
  logic        reset_q;
  // occupancy rebuilt from port traffic
  int          rob_used;
  int          free_left;
  logic        fire;

  assign fire = dispatch_valid && dispatch_ready;

  // state is only defined from the second reset edge on
  always_ff @(posedge clock) begin
    reset_q <= reset;
  end

  // entries in flight and spare tags, as seen at the ports
  always_ff @(posedge clock) begin
    if (reset) begin
      rob_used  <= 0;
      free_left <= `FREE_LIST_DEPTH;
    end else begin
      rob_used  <= rob_used + int'(fire) - int'(retire_valid);
      free_left <= free_left - int'(fire && dispatch_has_dest)
                   + int'(retire_valid && retire_has_dest);
    end
  end

  retire_idle_in_reset: assert property (
    @(posedge clock) (reset && reset_q) |-> !retire_valid)
    else begin
      $error("retire_valid high while reset is held");
      fail_count++;
    end

  // full rob or empty free list must stall dispatch
  stall_on_full: assert property (
    @(posedge clock) disable iff (reset)
    ((rob_used == `ROB_DEPTH) || (free_left == 0)) |-> !dispatch_ready)
    else begin
      $error("dispatch_ready high with no room left to dispatch");
      fail_count++;
    end

  // r31 owns tag 31 for good, so a retiring rename never carries it
  retire_tag_range: assert property (
    @(posedge clock) disable iff (reset)
    (retire_valid && retire_has_dest) |->
      ((retire_new_tag < `NUM_PHYS_REG) && (retire_new_tag != `ZERO_REG)))
    else begin
      $error("retire_new_tag outside the renameable tag range");
      fail_count++;
    end

endmodule

bind rename_core rename_core_assertions u_assert (
  .clock             (clock),
  .reset             (reset),
  .dispatch_valid    (dispatch_valid),
  .dispatch_ready    (dispatch_ready),
  .dispatch_has_dest (dispatch_has_dest),
  .retire_valid      (retire_valid),
  .retire_has_dest   (retire_has_dest),
  .retire_new_tag    (retire_new_tag)
);

`default_nettype wire

// File: dv/tb_rename_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module tb_rename_core
  import rename_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic       clock;
  logic       reset;
  logic       dispatch_valid;
  inst_word_t dispatch_inst;
  logic       dispatch_ready;
  logic       dispatch_has_dest;
  phys_tag_t  dispatch_dest_tag;
  phys_tag_t  src_a_tag;
  phys_tag_t  src_b_tag;
  logic       src_a_ready;
  logic       src_b_ready;
  logic       complete_valid;
  phys_tag_t  complete_tag;
  logic       retire_valid;
  logic       retire_has_dest;
  arch_reg_t  retire_arch_reg;
  phys_tag_t  retire_new_tag;
  phys_tag_t  retire_old_tag;

  integer seed;

  // reference model state
  phys_tag_t  ref_map_tag   [`NUM_ARCH_REG];
  logic       ref_map_ready [`NUM_ARCH_REG];
  phys_tag_t  ref_free_q    [$];
  rob_entry_t ref_rob_q     [$];
  // dispatched tags not yet completed
  phys_tag_t  pending_q     [$];

  rename_core u_dut (
    .clock             (clock),
    .reset             (reset),
    .dispatch_valid    (dispatch_valid),
    .dispatch_inst     (dispatch_inst),
    .dispatch_ready    (dispatch_ready),
    .dispatch_has_dest (dispatch_has_dest),
    .dispatch_dest_tag (dispatch_dest_tag),
    .src_a_tag         (src_a_tag),
    .src_b_tag         (src_b_tag),
    .src_a_ready       (src_a_ready),
    .src_b_ready       (src_b_ready),
    .complete_valid    (complete_valid),
    .complete_tag      (complete_tag),
    .retire_valid      (retire_valid),
    .retire_has_dest   (retire_has_dest),
    .retire_arch_reg   (retire_arch_reg),
    .retire_new_tag    (retire_new_tag),
    .retire_old_tag    (retire_old_tag)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // error exits
  //////////////////////////////////////////////////

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    stop_fail($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic void init_model();
    // identity map, spare tags 32..39 in order
    for (int i = 0; i < `NUM_ARCH_REG; i++) begin
      ref_map_tag[i]   = phys_tag_t'(i);
      ref_map_ready[i] = 1'b1;
    end
    ref_free_q.delete();
    ref_rob_q.delete();
    pending_q.delete();
    for (int i = 0; i < `FREE_LIST_DEPTH; i++) begin
      ref_free_q.push_back(phys_tag_t'(`NUM_ARCH_REG + i));
    end
  endfunction

  // decode by bit position, lookup before the edge, then rename
  function automatic void ref_rename(input logic [31:0] inst, output logic has_dest,
                                     output phys_tag_t dest_tag, output phys_tag_t a_tag,
                                     output logic a_rdy, output phys_tag_t b_tag,
                                     output logic b_rdy);
    logic [5:0] opc;
    arch_reg_t  dst;
    arch_reg_t  sa;
    arch_reg_t  sb;
    rob_entry_t ent;
    opc = inst[31:26];
    dst = `ZERO_REG;
    sa  = `ZERO_REG;
    sb  = `ZERO_REG;
    if (opc >= `OPC_INTA && opc <= `OPC_INTM) begin
      dst = inst[4:0];
      sa  = inst[25:21];
      sb  = inst[20:16];
    end else if (opc == `OPC_LDL || opc == `OPC_LDQ) begin
      dst = inst[25:21];
      sb  = inst[20:16];
    end else if (opc == `OPC_STL || opc == `OPC_STQ) begin
      sa  = inst[25:21];
      sb  = inst[20:16];
    end
    has_dest = (dst != `ZERO_REG);
    a_tag    = ref_map_tag[sa];
    a_rdy    = ref_map_ready[sa];
    b_tag    = ref_map_tag[sb];
    b_rdy    = ref_map_ready[sb];
    ent.arch_dest = dst;
    ent.old_tag   = ref_map_tag[dst];
    ent.has_dest  = has_dest;
    ent.done      = !has_dest;
    if (has_dest) begin
      dest_tag         = ref_free_q.pop_front();
      ref_map_tag[dst] = dest_tag;
      ref_map_ready[dst] = 1'b0;
    end else begin
      dest_tag = `ZERO_REG;
    end
    ent.new_tag = dest_tag;
    ref_rob_q.push_back(ent);
  endfunction

  function automatic void apply_complete(input phys_tag_t tag);
    for (int i = 0; i < `NUM_ARCH_REG; i++) begin
      if (ref_map_tag[i] == tag) begin
        ref_map_ready[i] = 1'b1;
      end
    end
    foreach (ref_rob_q[i]) begin
      if (ref_rob_q[i].has_dest && ref_rob_q[i].new_tag == tag) begin
        ref_rob_q[i].done = 1'b1;
      end
    end
  endfunction

  //////////////////////////////////////////////////
  // comparing process
  //////////////////////////////////////////////////

  // mid-cycle sample, then model steps over the coming edge
  always @(negedge clock) begin
    logic       exp_ready;
    logic       exp_retire;
    logic       e_has;
    phys_tag_t  e_tag;
    phys_tag_t  e_a_tag;
    phys_tag_t  e_b_tag;
    logic       e_a_rdy;
    logic       e_b_rdy;
    rob_entry_t head;
    if (!reset) begin
      exp_ready = (ref_rob_q.size() < `ROB_DEPTH) && (ref_free_q.size() != 0);
      assert (dispatch_ready === exp_ready)
        else report_value("dispatch_ready", dispatch_ready, exp_ready);
      exp_retire = 1'b0;
      if (ref_rob_q.size() != 0) begin
        exp_retire = ref_rob_q[0].done;
      end
      assert (retire_valid === exp_retire)
        else report_value("retire_valid", retire_valid, exp_retire);
      // in-order retire, old tag back to the free list tail
      if (exp_retire) begin
        head = ref_rob_q.pop_front();
        assert (retire_has_dest === head.has_dest)
          else report_value("retire_has_dest", retire_has_dest, head.has_dest);
        if (head.has_dest) begin
          assert (retire_arch_reg === head.arch_dest)
            else report_value("retire_arch_reg", retire_arch_reg, head.arch_dest);
          assert (retire_new_tag === head.new_tag)
            else report_value("retire_new_tag", retire_new_tag, head.new_tag);
          assert (retire_old_tag === head.old_tag)
            else report_value("retire_old_tag", retire_old_tag, head.old_tag);
          ref_free_q.push_back(head.old_tag);
        end
      end
      if (dispatch_valid === 1'b1 && exp_ready) begin
        ref_rename(dispatch_inst, e_has, e_tag, e_a_tag, e_a_rdy, e_b_tag, e_b_rdy);
        assert (dispatch_has_dest === e_has)
          else report_value("dispatch_has_dest", dispatch_has_dest, e_has);
        assert (dispatch_dest_tag === e_tag)
          else report_value("dispatch_dest_tag", dispatch_dest_tag, e_tag);
        assert (src_a_tag === e_a_tag) else report_value("src_a_tag", src_a_tag, e_a_tag);
        assert (src_a_ready === e_a_rdy) else report_value("src_a_ready", src_a_ready, e_a_rdy);
        assert (src_b_tag === e_b_tag) else report_value("src_b_tag", src_b_tag, e_b_tag);
        assert (src_b_ready === e_b_rdy) else report_value("src_b_ready", src_b_ready, e_b_rdy);
        if (e_has) begin
          pending_q.push_back(e_tag);
        end
      end
      // completion lands after rename, so a same-edge rename keeps its clear
      if (complete_valid === 1'b1) begin
        apply_complete(complete_tag);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // r31 in about one of eight picks
  function automatic arch_reg_t rand_reg();
    if (($random(seed) & 7) == 0) begin
      return 5'd31;
    end
    return arch_reg_t'($unsigned($random(seed)) % 32);
  endfunction

  // kind 1 load, 2 store, 3 other opcode, else operate
  function automatic inst_word_t rand_inst(input int kind);
    inst_word_t w;
    w       = inst_word_t'($random(seed));
    w.op.ra = rand_reg();
    w.op.rb = rand_reg();
    w.op.rc = rand_reg();
    case (kind)
      1:       w.op.opcode = ($random(seed) & 1) ? `OPC_LDQ : `OPC_LDL;
      2:       w.op.opcode = ($random(seed) & 1) ? `OPC_STQ : `OPC_STL;
      3:       w.op.opcode = 6'h30 + 6'($unsigned($random(seed)) % 8);
      default: w.op.opcode = `OPC_INTA + 6'($unsigned($random(seed)) % 4);
    endcase
    return w;
  endfunction

  function automatic inst_word_t make_op(input logic [5:0] opc, input arch_reg_t ra,
                                         input arch_reg_t rb, input arch_reg_t rc);
    inst_word_t w;
    w           = inst_word_t'($random(seed));
    w.op.opcode = opc;
    w.op.ra     = ra;
    w.op.rb     = rb;
    w.op.rc     = rc;
    return w;
  endfunction

  function automatic inst_word_t make_mem(input logic [5:0] opc, input arch_reg_t ra,
                                          input arch_reg_t rb);
    inst_word_t w;
    w            = inst_word_t'($random(seed));
    w.mem.opcode = opc;
    w.mem.ra     = ra;
    w.mem.rb     = rb;
    return w;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // maybe complete one outstanding tag this cycle
  task automatic pick_complete(input bit en);
    int idx;
    complete_valid = 1'b0;
    if (en && pending_q.size() != 0 && ($random(seed) & 1)) begin
      idx = $unsigned($random(seed)) % pending_q.size();
      complete_tag = pending_q[idx];
      pending_q.delete(idx);
      complete_valid = 1'b1;
    end
  endtask

  // hold valid until ready is seen mid-cycle
  task automatic send(input inst_word_t inst, input bit en);
    int waited;
    waited         = 0;
    dispatch_valid = 1'b1;
    dispatch_inst  = inst;
    pick_complete(en);
    @(negedge clock);
    while (dispatch_ready !== 1'b1 && waited <= TIMEOUT) begin
      waited++;
      next_cycle();
      pick_complete(en);
      @(negedge clock);
    end
    if (waited > TIMEOUT) begin
      stop_fail("timeout while waiting for dispatch_ready");
    end else begin
      next_cycle();
      dispatch_valid = 1'b0;
      complete_valid = 1'b0;
    end
  endtask

  task automatic idle(input bit en);
    dispatch_valid = 1'b0;
    pick_complete(en);
    next_cycle();
    complete_valid = 1'b0;
  endtask

  task automatic complete_oldest();
    if (pending_q.size() == 0) begin
      stop_fail("no outstanding tag left to complete");
    end else begin
      dispatch_valid = 1'b0;
      complete_tag   = pending_q.pop_front();
      complete_valid = 1'b1;
      next_cycle();
      complete_valid = 1'b0;
    end
  endtask

  // complete everything and let the rob empty
  task automatic drain();
    int waited;
    waited = 0;
    while ((ref_rob_q.size() != 0 || pending_q.size() != 0) && waited <= TIMEOUT) begin
      idle(1'b1);
      waited++;
    end
    if (waited > TIMEOUT) begin
      stop_fail("timeout while draining the reorder buffer");
    end
  endtask

  task automatic check_stall();
    dispatch_valid = 1'b0;
    @(negedge clock);
    assert (dispatch_ready === 1'b0) else report_value("dispatch_ready", dispatch_ready, 0);
    next_cycle();
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    inst_word_t w;
    seed           = 45255;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_inst  = '0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    init_model();
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    // first rename takes tag 32, sources straight from the identity map
    send(make_op(`OPC_INTA, 5'd3, 5'd7, 5'd5), 1'b0);
    send(make_op(`OPC_INTL, 5'd5, 5'd31, 5'd6), 1'b0);
    complete_oldest();
    send(make_op(`OPC_INTS, 5'd5, 5'd5, 5'd7), 1'b0);
    // load renames r5 again, ready clears
    send(make_mem(`OPC_LDQ, 5'd5, 5'd2), 1'b0);
    send(make_op(`OPC_INTM, 5'd5, 5'd1, 5'd31), 1'b0);
    send(make_mem(`OPC_STL, 5'd4, 5'd5), 1'b0);
    send(make_op(6'h1a, 5'd8, 5'd9, 5'd10), 1'b0);
    drain();

    // mixed traffic, completions out of order
    for (int i = 0; i < 400; i++) begin
      send(rand_inst($unsigned($random(seed)) % 5), 1'b1);
      if (($random(seed) & 7) == 0) begin
        idle(1'b1);
      end
    end
    drain();

    // eight renames with no completion empty the free list
    for (int i = 0; i < 8; i++) begin
      w = rand_inst(0);
      w.op.rc = arch_reg_t'($unsigned($random(seed)) % 31);
      send(w, 1'b0);
    end
    check_stall();
    send(rand_inst(0), 1'b1);
    drain();

    // blocked head plus fifteen no-dest entries fill the rob
    w = rand_inst(0);
    w.op.rc = 5'd12;
    send(w, 1'b0);
    for (int i = 0; i < 15; i++) begin
      w = rand_inst((i % 3 == 0) ? 0 : (i % 3) + 1);
      if (i % 3 == 0) begin
        w.op.rc = 5'd31;
      end
      send(w, 1'b0);
    end
    check_stall();
    send(rand_inst(0), 1'b1);
    drain();

    if (u_dut.u_assert.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_fail($sformatf("%0d concurrent assertion failures", u_dut.u_assert.fail_count));
    end
  end

endmodule

`default_nettype wire

// File: rename_core.f
+incdir+design
design/rename_pkg.sv
design/map_table.sv
design/free_list.sv
design/dispatch_stage.sv
design/reorder_buffer.sv
design/rename_core.sv
dv/rename_core_assertions.sv
dv/tb_rename_core.sv
